//--- src/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int XLEN   = 32;
    localparam int MEM_AW = 8;  // 256 words

    // Primary opcode field in instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-type funct field in instr[5:0]
    typedef enum logic [5:0] {
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_SLT = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        FETCH, DECODE, MEM_ADR, MEM_READ, MEM_WB, MEM_WRITE,
        EXECUTE, ALU_WB, BRANCH, ADDI_EXEC, ADDI_WB, JUMP
    } state_e;

    typedef enum logic [2:0] {
        ALU_AND = 3'b000,
        ALU_OR  = 3'b001,
        ALU_ADD = 3'b010,
        ALU_SUB = 3'b110,
        ALU_SLT = 3'b111
    } alu_op_e;

    typedef enum logic [1:0] {
        SRCB_REG        = 2'b00,
        SRCB_FOUR       = 2'b01,
        SRCB_SIGNIMM    = 2'b10,
        SRCB_SIGNIMM_SH = 2'b11
    } srcb_e;

    typedef enum logic [1:0] {
        PC_ALU    = 2'b00,
        PC_ALUOUT = 2'b01,
        PC_JUMP   = 2'b10
    } pcsrc_e;

    typedef struct packed {
        logic    mem_to_reg;  // Write back MDR instead of ALUOut
        logic    reg_dst;     // rd instead of rt
        logic    i_or_d;      // Data address instead of PC
        pcsrc_e  pc_src;
        srcb_e   alu_src_b;
        logic    alu_src_a;   // A register instead of PC
        logic    ir_write;
        logic    mem_write;
        logic    pc_write;
        logic    branch;
        logic    reg_write;
        alu_op_e alu_ctrl;
    } ctrl_t;

    typedef struct packed {
        logic            we;
        logic [XLEN-1:0] addr;   // Byte address
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic            valid;
        logic [4:0]      waddr;
        logic [XLEN-1:0] wdata;
    } wb_trace_t;

endpackage

`default_nettype wire

//--- src/mips_alu.sv
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
    input  wire [mips_pkg::XLEN-1:0]  a_i,
    input  wire [mips_pkg::XLEN-1:0]  b_i,
    input  mips_pkg::alu_op_e         op_i,
    output logic [mips_pkg::XLEN-1:0] y_o,
    output logic                      zero_o
);

    import mips_pkg::*;

    always_comb
    begin
        case (op_i)
            ALU_AND: y_o = a_i & b_i;
            ALU_OR:  y_o = a_i | b_i;
            ALU_ADD: y_o = a_i + b_i;
            ALU_SUB: y_o = a_i - b_i;
            // Signed compare
            ALU_SLT: y_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            default: y_o = a_i + b_i;
        endcase
    end

    assign zero_o = (y_o == '0);

endmodule

`default_nettype wire

//--- src/mips_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
    input  wire                      clk_i,
    input  wire                      reset_i,
    input  wire                      we_i,
    input  wire [4:0]                ra1_i,
    input  wire [4:0]                ra2_i,
    input  wire [4:0]                wa_i,
    input  wire [mips_pkg::XLEN-1:0] wd_i,
    output logic [mips_pkg::XLEN-1:0] rd1_o,
    output logic [mips_pkg::XLEN-1:0] rd2_o
);

    import mips_pkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we_i)
        begin
            regs[wa_i] <= wd_i;  // $0 may be written but never read back
        end
    end

    assign rd1_o = (ra1_i == 5'd0) ? '0 : regs[ra1_i];
    assign rd2_o = (ra2_i == 5'd0) ? '0 : regs[ra2_i];

endmodule

`default_nettype wire

//--- src/mips_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module mips_datapath (
    input  wire                           clk_i,
    input  wire                           reset_i,
    input  mips_pkg::ctrl_t               ctrl_i,
    input  wire [mips_pkg::XLEN-1:0]      mem_rdata_i,
    output mips_pkg::opcode_e             op_o,
    output mips_pkg::funct_e              funct_o,
    output mips_pkg::mem_req_t            mem_req_o,
    output mips_pkg::wb_trace_t           wb_o
);

    import mips_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] ir_q;
    logic [XLEN-1:0] mdr_q;
    logic [XLEN-1:0] a_q;
    logic [XLEN-1:0] b_q;
    logic [XLEN-1:0] alu_out_q;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] alu_y;
    logic [XLEN-1:0] sign_imm;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] wd;
    logic [4:0]      wa;
    logic            zero;
    logic            pc_en;

    // Control state
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            pc_q <= '0;
            ir_q <= '0;
        end
        else
        begin
            if (pc_en)
                pc_q <= pc_next;
            if (ctrl_i.ir_write)
                ir_q <= mem_rdata_i;
        end
    end

    // Non-architectural registers load every cycle
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            mdr_q     <= '0;
            a_q       <= '0;
            b_q       <= '0;
            alu_out_q <= '0;
        end
        else
        begin
            mdr_q     <= mem_rdata_i;
            a_q       <= rd1;
            b_q       <= rd2;
            alu_out_q <= alu_y;
        end
    end

    assign op_o     = opcode_e'(ir_q[31:26]);
    assign funct_o  = funct_e'(ir_q[5:0]);
    assign sign_imm = {{16{ir_q[15]}}, ir_q[15:0]};

    assign wa = ctrl_i.reg_dst ? ir_q[15:11] : ir_q[20:16];
    assign wd = ctrl_i.mem_to_reg ? mdr_q : alu_out_q;

    mips_regfile u_regfile (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .we_i    (ctrl_i.reg_write),
        .ra1_i   (ir_q[25:21]),
        .ra2_i   (ir_q[20:16]),
        .wa_i    (wa),
        .wd_i    (wd),
        .rd1_o   (rd1),
        .rd2_o   (rd2)
    );

    assign src_a = ctrl_i.alu_src_a ? a_q : pc_q;

    always_comb
    begin
        case (ctrl_i.alu_src_b)
            SRCB_REG:        src_b = b_q;
            SRCB_FOUR:       src_b = 32'd4;
            SRCB_SIGNIMM:    src_b = sign_imm;
            SRCB_SIGNIMM_SH: src_b = {sign_imm[XLEN-3:0], 2'b00};
            default:         src_b = b_q;
        endcase
    end

    mips_alu u_alu (
        .a_i    (src_a),
        .b_i    (src_b),
        .op_i   (ctrl_i.alu_ctrl),
        .y_o    (alu_y),
        .zero_o (zero)
    );

    assign pc_en = ctrl_i.pc_write | (ctrl_i.branch & zero);

    always_comb
    begin
        case (ctrl_i.pc_src)
            PC_ALUOUT: pc_next = alu_out_q;
            PC_JUMP:   pc_next = {pc_q[31:28], ir_q[25:0], 2'b00};  // Region of PC + 4
            default:   pc_next = alu_y;
        endcase
    end

    assign mem_req_o.we    = ctrl_i.mem_write;
    assign mem_req_o.addr  = ctrl_i.i_or_d ? alu_out_q : pc_q;
    assign mem_req_o.wdata = b_q;  // rt value for sw

    assign wb_o.valid = ctrl_i.reg_write;
    assign wb_o.waddr = wa;
    assign wb_o.wdata = wd;

endmodule

`default_nettype wire

//--- src/mips_controller_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mips_controller_fsm (
    input  wire               clk_i,
    input  wire               reset_i,
    input  mips_pkg::opcode_e op_i,
    input  mips_pkg::funct_e  funct_i,
    output mips_pkg::ctrl_t   ctrl_o
);

    import mips_pkg::*;

    state_e state_q;
    state_e state_d;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            state_q <= FETCH;
        else
            state_q <= state_d;
    end

    // Next state
    always_comb
    begin
        state_d = FETCH;
        case (state_q)
            FETCH:     state_d = DECODE;
            DECODE:
            begin
                case (op_i)
                    OP_LW, OP_SW: state_d = MEM_ADR;
                    OP_RTYPE:     state_d = EXECUTE;
                    OP_BEQ:       state_d = BRANCH;
                    OP_ADDI:      state_d = ADDI_EXEC;
                    OP_J:         state_d = JUMP;
                    default:      state_d = FETCH;  // Unsupported opcode is skipped
                endcase
            end
            MEM_ADR:   state_d = (op_i == OP_LW) ? MEM_READ : MEM_WRITE;
            MEM_READ:  state_d = MEM_WB;
            EXECUTE:   state_d = ALU_WB;
            ADDI_EXEC: state_d = ADDI_WB;
            default:   state_d = FETCH;  // All write-back, branch and jump states
        endcase
    end

    // Control word per state
    always_comb
    begin
        ctrl_o           = '0;
        ctrl_o.pc_src    = PC_ALU;
        ctrl_o.alu_src_b = SRCB_REG;
        ctrl_o.alu_ctrl  = ALU_ADD;
        case (state_q)
            FETCH:
            begin
                ctrl_o.alu_src_b = SRCB_FOUR;  // PC + 4
                ctrl_o.ir_write  = 1'b1;
                ctrl_o.pc_write  = 1'b1;
            end
            DECODE:    ctrl_o.alu_src_b = SRCB_SIGNIMM_SH;  // Branch target into ALUOut
            MEM_ADR, ADDI_EXEC:
            begin
                ctrl_o.alu_src_a = 1'b1;
                ctrl_o.alu_src_b = SRCB_SIGNIMM;
            end
            MEM_READ:  ctrl_o.i_or_d = 1'b1;
            MEM_WB:
            begin
                ctrl_o.mem_to_reg = 1'b1;
                ctrl_o.reg_write  = 1'b1;
            end
            MEM_WRITE:
            begin
                ctrl_o.i_or_d    = 1'b1;
                ctrl_o.mem_write = 1'b1;
            end
            EXECUTE:
            begin
                ctrl_o.alu_src_a = 1'b1;
                case (funct_i)
                    F_SUB:   ctrl_o.alu_ctrl = ALU_SUB;
                    F_AND:   ctrl_o.alu_ctrl = ALU_AND;
                    F_OR:    ctrl_o.alu_ctrl = ALU_OR;
                    F_SLT:   ctrl_o.alu_ctrl = ALU_SLT;
                    default: ctrl_o.alu_ctrl = ALU_ADD;
                endcase
            end
            ALU_WB:
            begin
                ctrl_o.reg_dst   = 1'b1;
                ctrl_o.reg_write = 1'b1;
            end
            ADDI_WB:   ctrl_o.reg_write = 1'b1;  // rt gets ALUOut
            BRANCH:
            begin
                ctrl_o.alu_src_a = 1'b1;
                ctrl_o.alu_ctrl  = ALU_SUB;    // Zero when A == B
                ctrl_o.pc_src    = PC_ALUOUT;
                ctrl_o.branch    = 1'b1;
            end
            JUMP:
            begin
                ctrl_o.pc_src   = PC_JUMP;
                ctrl_o.pc_write = 1'b1;
            end
            default: ;
        endcase
    end

    // Register file and memory are never written by the same instruction step
    a_no_dual_write: assert property (@(posedge clk_i) disable iff (reset_i)
        !(ctrl_o.mem_write && ctrl_o.reg_write));

endmodule

`default_nettype wire

//--- src/mips_mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mips_mem_arbiter (
    input  mips_pkg::mem_req_t  core_req_i,
    input  mips_pkg::mem_req_t  dbg_req_i,
    input  wire                 dbg_en_i,
    output mips_pkg::mem_req_t  mem_req_o
);

    // Debug port always wins
    assign mem_req_o = dbg_en_i ? dbg_req_i : core_req_i;

    // Debug may only take the bus while the core is held or parked,
    // so a core store must never be dropped
    always_comb
    begin
        a_no_dropped_store: assert (!(dbg_en_i && core_req_i.we))
            else $error("Debug access collides with core store");
    end

endmodule

`default_nettype wire

//--- src/mips_memory.sv
`timescale 1ns/1ps
`default_nettype none

module mips_memory (
    input  wire                       clk_i,
    input  mips_pkg::mem_req_t        req_i,
    output logic [mips_pkg::XLEN-1:0] rdata_o
);

    import mips_pkg::*;

    logic [XLEN-1:0]   mem [2**MEM_AW];
    logic [MEM_AW-1:0] idx;

    assign idx     = req_i.addr[MEM_AW+1:2];  // Word index
    assign rdata_o = mem[idx];

    always_ff @(posedge clk_i)
    begin
        if (req_i.we)
            mem[idx] <= req_i.wdata;
    end

endmodule

`default_nettype wire

//--- src/mips_top.sv
`timescale 1ns/1ps
`default_nettype none

module mips_top (
    input  wire                       clk_i,
    input  wire                       reset_i,
    input  wire                       dbg_en_i,
    input  mips_pkg::mem_req_t        dbg_req_i,
    output logic [mips_pkg::XLEN-1:0] dbg_rdata_o,
    output mips_pkg::wb_trace_t       wb_o
);

    import mips_pkg::*;

    ctrl_t           ctrl;
    opcode_e         op;
    funct_e          funct;
    mem_req_t        core_req;
    mem_req_t        mem_req;
    logic [XLEN-1:0] mem_rdata;

    mips_controller_fsm u_ctrl (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .op_i    (op),
        .funct_i (funct),
        .ctrl_o  (ctrl)
    );

    mips_datapath u_dp (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .ctrl_i      (ctrl),
        .mem_rdata_i (mem_rdata),
        .op_o        (op),
        .funct_o     (funct),
        .mem_req_o   (core_req),
        .wb_o        (wb_o)
    );

    mips_mem_arbiter u_arb (
        .core_req_i (core_req),
        .dbg_req_i  (dbg_req_i),
        .dbg_en_i   (dbg_en_i),
        .mem_req_o  (mem_req)
    );

    mips_memory u_mem (
        .clk_i   (clk_i),
        .req_i   (mem_req),
        .rdata_o (mem_rdata)
    );

    assign dbg_rdata_o = mem_rdata;  // Shared read bus

endmodule

`default_nettype wire

//--- tb/tb_mips_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_top;

    import mips_pkg::*;

    localparam int STIM_WORDS = 3 * 64;  // Three words per record
    localparam int MEM_WORDS  = 2**MEM_AW;
    localparam int SETTLE     = 20;

    logic            clk;
    logic            reset;
    logic            dbg_en;
    mem_req_t        dbg_req;
    logic [XLEN-1:0] dbg_rdata;
    wb_trace_t       wb;

    logic [XLEN-1:0] stim [STIM_WORDS];
    logic [XLEN-1:0] prog_img [MEM_WORDS];
    logic            prog_used [MEM_WORDS];
    wb_trace_t       exp_wb [$];
    logic [XLEN-1:0] exp_addr [$];
    logic [XLEN-1:0] exp_data [$];
    int              wb_idx      = 0;
    int              n_prog      = 0;
    int              cycle_cnt   = 0;
    int              cycle_limit = 0;
    logic            tracing     = 1'b0;

    mips_top u_dut (
        .clk_i       (clk),
        .reset_i     (reset),
        .dbg_en_i    (dbg_en),
        .dbg_req_i   (dbg_req),
        .dbg_rdata_o (dbg_rdata),
        .wb_o        (wb)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_wb(input wb_trace_t got, input wb_trace_t exp);
        if (got !== exp)
            stop_on_error($sformatf(
                "CHECK FAILED wb_o: got waddr=%h wdata=%h, expected waddr=%h wdata=%h",
                got.waddr, got.wdata, exp.waddr, exp.wdata));
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] addr,
                              input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("CHECK FAILED %s at %h: got %h, expected %h",
                name, addr, got, exp));
    endtask

    task automatic load_stim();
        int              base;
        logic [XLEN-1:0] addr;
        wb_trace_t       rec;
        for (int i = 0; i < STIM_WORDS; i++)
            stim[i] = '0;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            prog_img[i]  = '0;
            prog_used[i] = 1'b0;
        end
        $readmemh("tb/mips_stim.txt", stim);
        for (int r = 0; r < STIM_WORDS / 3; r++)
        begin
            base = 3 * r;
            addr = stim[base + 1];
            case (stim[base])
                32'd1:
                begin
                    prog_img[addr[MEM_AW+1:2]]  = stim[base + 2];
                    prog_used[addr[MEM_AW+1:2]] = 1'b1;
                    n_prog++;
                end
                32'd2:
                begin
                    rec.valid = 1'b1;
                    rec.waddr = addr[4:0];
                    rec.wdata = stim[base + 2];
                    exp_wb.push_back(rec);
                end
                32'd3:
                begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(stim[base + 2]);
                end
                default: ;  // End marker or empty slot
            endcase
        end
        if (n_prog == 0 || exp_wb.size() == 0)
            stop_on_error("Stimulus file holds no program or no expected write-backs");
    endtask

    task automatic dbg_write(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
        @(negedge clk);
        dbg_req.we    = 1'b1;
        dbg_req.addr  = addr;
        dbg_req.wdata = data;
    endtask

    task automatic dbg_read(input logic [XLEN-1:0] addr, output logic [XLEN-1:0] data);
        @(negedge clk);
        dbg_req.we    = 1'b0;
        dbg_req.addr  = addr;
        dbg_req.wdata = '0;
        @(posedge clk);
        data = dbg_rdata;  // Combinational read with no write pending
    endtask

    // Write-back monitor sampled mid-cycle
    always @(negedge clk)
    begin
        if (tracing && wb.valid)
        begin
            if (wb_idx >= exp_wb.size())
                stop_on_error($sformatf("Unexpected write-back to register %0d after the last one",
                    wb.waddr));
            else
            begin
                check_wb(wb, exp_wb[wb_idx]);
                wb_idx++;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit)
        begin
            $display("Timeout after %0d cycles, only %0d write-backs seen", cycle_cnt, wb_idx);
            $display("Test FAILED");
            $fatal(1);
        end
    end

    initial
    begin
        logic [XLEN-1:0] rdata;
        void'($urandom(42));
        reset    = 1'b1;
        dbg_en   = 1'b1;
        dbg_req  = '0;
        load_stim();
        // Load, run, settle and readback times doubled for margin
        cycle_limit = 2 * (5 * n_prog + MEM_WORDS + 3 + SETTLE + exp_addr.size() + n_prog);

        repeat (3) @(negedge clk);
        for (int i = 0; i < MEM_WORDS; i++)
            dbg_write(i * 4, prog_used[i] ? prog_img[i] : $urandom());  // Random filler words

        @(negedge clk);
        dbg_req = '0;
        dbg_en  = 1'b0;
        tracing = 1'b1;
        reset   = 1'b0;

        while (wb_idx < exp_wb.size())
            @(negedge clk);
        repeat (SETTLE) @(negedge clk);  // Parked loop must stay quiet

        // Hold core in reset so fetches cannot see debug data
        reset   = 1'b1;
        tracing = 1'b0;
        dbg_en  = 1'b1;
        for (int i = 0; i < exp_addr.size(); i++)
        begin
            dbg_read(exp_addr[i], rdata);
            check_word("dbg_rdata_o", exp_addr[i], rdata, exp_data[i]);
        end
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            if (prog_used[i])
            begin
                dbg_read(i * 4, rdata);
                check_word("dbg_rdata_o", i * 4, rdata, prog_img[i]);
            end
        end
        @(negedge clk);
        dbg_en = 1'b0;

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
src/mips_pkg.sv
src/mips_alu.sv
src/mips_regfile.sv
src/mips_datapath.sv
src/mips_controller_fsm.sv
src/mips_mem_arbiter.sv
src/mips_memory.sv
src/mips_top.sv
tb/tb_mips_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_mips_top -f compile.f -o tb_sim
out=$(./obj_dir/tb_sim 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

//--- tb/mips_stim.txt
// Columns: kind, address or register, data. Kind 1 is a program word at a byte address,
// kind 2 an expected write-back (register, value) in program order, kind 3 an expected memory word
1 00000000 20010005
1 00000004 2002FFFD
1 00000008 00221820
1 0000000C 00222022
1 00000010 00222824
1 00000014 00223025
1 00000018 0041382A
1 0000001C 0022402A
1 00000020 20200007
1 00000024 00014820
1 00000028 AC040080
1 0000002C 8C0A0080
1 00000030 11440001
1 00000034 200B0063
1 00000038 10220001
1 0000003C 200C0123
1 00000040 AC0C0084
1 00000044 08000013
1 00000048 200D0001
1 0000004C 200EFFFF
1 00000050 01C17820
1 00000054 AC0E0088
1 00000058 08000016
2 00000001 00000005
2 00000002 FFFFFFFD
2 00000003 00000002
2 00000004 00000008
2 00000005 00000005
2 00000006 FFFFFFFD
2 00000007 00000001
2 00000008 00000000
2 00000000 0000000C
2 00000009 00000005
2 0000000A 00000008
2 0000000C 00000123
2 0000000E FFFFFFFF
2 0000000F 00000004
3 00000080 00000008
3 00000084 00000123
3 00000088 FFFFFFFF
0 00000000 00000000
